//--- filelist.f
src/sdram_geom_pkg.sv
src/sdram_seq_pkg.sv
src/burst_job_if.sv
src/word_access_port.sv
src/stream_write_buffer.sv
src/burst_sequencer.sv
src/sdram_user_bridge.sv
tests/tb_clock.sv
tests/sdram_ctrl_model.sv
tests/tb_sdram_user_bridge.sv

//--- src/burst_job_if.sv
interface burst_job_if;

    logic                       req;       // held until done
    sdram_geom_pkg::addr_t      addr;      // stable while req high
    sdram_geom_pkg::word_t      wr_word;   // write data for word_idx
    logic                       done;      // one cycle at job end
    sdram_geom_pkg::burst_len_t word_idx;  // word number inside the burst
    logic                       word_stb;  // one cycle per word moved
    sdram_geom_pkg::word_t      rd_word;   // read data, valid with word_stb

    modport requester (
        output req, addr, wr_word,
        input  done, word_idx, word_stb, rd_word
    );

    modport sequencer (
        input  req, addr, wr_word,
        output done, word_idx, word_stb, rd_word
    );

endinterface

//--- src/burst_sequencer.sv
module burst_sequencer (
    input  logic                       clk,
    input  logic                       sys_rst_n,
    burst_job_if.sequencer             fill,
    burst_job_if.sequencer             single,
    burst_job_if.sequencer             flush,
    input  logic                       sdram_init_done,
    output sdram_geom_pkg::addr_t      sdram_rw_addr,
    output logic                       sdram_wr_req,
    output logic                       sdram_rd_req,
    output sdram_geom_pkg::burst_len_t sdram_wr_burst,
    output sdram_geom_pkg::burst_len_t sdram_rd_burst,
    output sdram_geom_pkg::word_t      sdram_din,
    input  logic                       sdram_wr_ack,
    input  logic                       sdram_rd_ack,
    input  sdram_geom_pkg::word_t      sdram_dout
);

    sdram_seq_pkg::seq_state_e  state;
    sdram_seq_pkg::job_sel_e    sel;
    sdram_seq_pkg::job_sel_e    pick;
    sdram_geom_pkg::burst_len_t word_cnt;
    sdram_geom_pkg::burst_len_t own_len;
    sdram_geom_pkg::addr_t      own_addr;
    logic                       own_req;
    logic                       is_read;
    logic                       xfer_ack;
    logic                       done_r;

    // fixed priority: fill, then single write, then flush
    always_comb begin
        if (fill.req) begin
            pick = sdram_seq_pkg::JOB_FILL;
        end else if (single.req) begin
            pick = sdram_seq_pkg::JOB_SINGLE;
        end else if (flush.req) begin
            pick = sdram_seq_pkg::JOB_FLUSH;
        end else begin
            pick = sdram_seq_pkg::JOB_NONE;
        end
    end

    // view of the current owner
    always_comb begin
        own_req   = 1'b0;
        own_addr  = '0;
        own_len   = '0;
        sdram_din = '0;
        case (sel)
            sdram_seq_pkg::JOB_FILL: begin
                own_req  = fill.req;
                own_addr = fill.addr;
                own_len  = sdram_geom_pkg::LEN_FILL;
            end
            sdram_seq_pkg::JOB_SINGLE: begin
                own_req   = single.req;
                own_addr  = single.addr;
                own_len   = sdram_geom_pkg::LEN_SINGLE;
                sdram_din = single.wr_word;
            end
            sdram_seq_pkg::JOB_FLUSH: begin
                own_req   = flush.req;
                own_addr  = flush.addr;
                own_len   = sdram_geom_pkg::LEN_FLUSH;
                sdram_din = flush.wr_word;
            end
            default: ;
        endcase
    end

    assign is_read  = (sel == sdram_seq_pkg::JOB_FILL);
    assign xfer_ack = (state == sdram_seq_pkg::SEQ_XFER)
                    && (is_read ? sdram_rd_ack : sdram_wr_ack);

    // word traffic back to the owner, idx and read data are shared
    assign fill.word_idx   = word_cnt;
    assign single.word_idx = word_cnt;
    assign flush.word_idx  = word_cnt;
    assign fill.rd_word    = sdram_dout;
    assign single.rd_word  = sdram_dout;
    assign flush.rd_word   = sdram_dout;
    assign fill.word_stb   = xfer_ack && (sel == sdram_seq_pkg::JOB_FILL);
    assign single.word_stb = xfer_ack && (sel == sdram_seq_pkg::JOB_SINGLE);
    assign flush.word_stb  = xfer_ack && (sel == sdram_seq_pkg::JOB_FLUSH);
    assign fill.done       = done_r && (sel == sdram_seq_pkg::JOB_FILL);
    assign single.done     = done_r && (sel == sdram_seq_pkg::JOB_SINGLE);
    assign flush.done      = done_r && (sel == sdram_seq_pkg::JOB_FLUSH);

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state          <= sdram_seq_pkg::SEQ_IDLE;
            sel            <= sdram_seq_pkg::JOB_NONE;
            word_cnt       <= '0;
            done_r         <= 1'b0;
            sdram_rw_addr  <= '0;
            sdram_wr_req   <= 1'b0;
            sdram_rd_req   <= 1'b0;
            sdram_wr_burst <= '0;
            sdram_rd_burst <= '0;
        end else begin
            done_r <= 1'b0;
            case (state)
                sdram_seq_pkg::SEQ_IDLE: begin
                    if (sdram_init_done && pick != sdram_seq_pkg::JOB_NONE) begin
                        sel   <= pick;
                        state <= sdram_seq_pkg::SEQ_ISSUE;
                    end
                end
                sdram_seq_pkg::SEQ_ISSUE: begin
                    sdram_rw_addr <= own_addr;
                    word_cnt      <= '0;   // word 0 is presented with the request
                    if (is_read) begin
                        sdram_rd_burst <= own_len;
                        sdram_rd_req   <= 1'b1;
                    end else begin
                        sdram_wr_burst <= own_len;
                        sdram_wr_req   <= 1'b1;
                    end
                    state <= sdram_seq_pkg::SEQ_XFER;
                end
                sdram_seq_pkg::SEQ_XFER: begin
                    if (xfer_ack) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == own_len - 1'b1) begin
                            sdram_rd_req <= 1'b0;  // length reached
                            sdram_wr_req <= 1'b0;
                            done_r       <= 1'b1;
                            state        <= sdram_seq_pkg::SEQ_FINISH;
                        end
                    end
                end
                sdram_seq_pkg::SEQ_FINISH: begin
                    if (!own_req) begin    // owner saw done
                        sel   <= sdram_seq_pkg::JOB_NONE;
                        state <= sdram_seq_pkg::SEQ_IDLE;
                    end
                end
                default: state <= sdram_seq_pkg::SEQ_IDLE;
            endcase
        end
    end

    a_req_excl : assert property (
        @(posedge clk) disable iff (!sys_rst_n) !(sdram_wr_req && sdram_rd_req)
    );

    // controller must not ack beyond the burst length
    a_cnt_bound : assert property (
        @(posedge clk) disable iff (!sys_rst_n)
        (state == sdram_seq_pkg::SEQ_FINISH) |-> !(sdram_rd_ack || sdram_wr_ack)
    );

endmodule

//--- src/sdram_geom_pkg.sv
package sdram_geom_pkg;

    typedef logic [23:0] addr_t;       // word address into sdram
    typedef logic [15:0] word_t;       // one data word
    typedef logic [21:0] line_tag_t;   // addr[23:2], names a four-word line
    typedef logic [19:0] block_tag_t;  // addr[23:4], names a stream block
    typedef logic [9:0]  burst_len_t;  // burst length in words

    localparam int LINE_WORDS   = 4;   // read line buffer depth
    localparam int STREAM_WORDS = 16;  // stream block depth

    // burst length issued for each kind of job
    localparam burst_len_t LEN_FILL   = burst_len_t'(LINE_WORDS);
    localparam burst_len_t LEN_SINGLE = burst_len_t'(1);
    localparam burst_len_t LEN_FLUSH  = burst_len_t'(STREAM_WORDS);

endpackage

//--- src/sdram_seq_pkg.sv
package sdram_seq_pkg;

    // burst sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,    // waiting for a job
        SEQ_ISSUE,   // load address and length, raise request
        SEQ_XFER,    // counting acks
        SEQ_FINISH   // done pulsed, wait for owner req to fall
    } seq_state_e;

    // owner of the controller port
    typedef enum logic [1:0] {
        JOB_NONE,
        JOB_FILL,    // read line fill
        JOB_SINGLE,  // single word write
        JOB_FLUSH    // stream block flush
    } job_sel_e;

endpackage

//--- src/sdram_user_bridge.sv
module sdram_user_bridge (
    input  logic                       clk,
    input  logic                       sys_rst_n,

    // user side
    input  sdram_geom_pkg::addr_t      address,
    input  sdram_geom_pkg::word_t      data_in,
    output sdram_geom_pkg::word_t      data_out,
    input  logic                       read_req,
    output logic                       read_ack,
    input  logic                       write_req,
    output logic                       write_ack,
    input  logic                       write_latch_address,
    input  logic                       write_en,
    output sdram_geom_pkg::addr_t      write_address,

    // burst controller side
    output sdram_geom_pkg::addr_t      sdram_rw_addr,
    output logic                       sdram_wr_req,
    output logic                       sdram_rd_req,
    output sdram_geom_pkg::burst_len_t sdram_wr_burst,
    output sdram_geom_pkg::burst_len_t sdram_rd_burst,
    output sdram_geom_pkg::word_t      sdram_din,
    input  logic                       sdram_wr_ack,
    input  logic                       sdram_rd_ack,
    input  sdram_geom_pkg::word_t      sdram_dout,
    input  logic                       sdram_init_done
);

    burst_job_if fill_job ();
    burst_job_if single_job ();
    burst_job_if flush_job ();

    word_access_port u_word_access_port (
        .clk       (clk),
        .sys_rst_n (sys_rst_n),
        .address   (address),
        .data_in   (data_in),
        .read_req  (read_req),
        .write_req (write_req),
        .write_en  (write_en),      // stream words invalidate the line too
        .read_ack  (read_ack),
        .write_ack (write_ack),
        .data_out  (data_out),
        .fill      (fill_job.requester),
        .single    (single_job.requester)
    );

    stream_write_buffer u_stream_write_buffer (
        .clk                 (clk),
        .sys_rst_n           (sys_rst_n),
        .address             (address),
        .data_in             (data_in),
        .write_latch_address (write_latch_address),
        .write_en            (write_en),
        .write_address       (write_address),
        .flush               (flush_job.requester)
    );

    burst_sequencer u_burst_sequencer (
        .clk             (clk),
        .sys_rst_n       (sys_rst_n),
        .fill            (fill_job.sequencer),
        .single          (single_job.sequencer),
        .flush           (flush_job.sequencer),
        .sdram_init_done (sdram_init_done),
        .sdram_rw_addr   (sdram_rw_addr),
        .sdram_wr_req    (sdram_wr_req),
        .sdram_rd_req    (sdram_rd_req),
        .sdram_wr_burst  (sdram_wr_burst),
        .sdram_rd_burst  (sdram_rd_burst),
        .sdram_din       (sdram_din),
        .sdram_wr_ack    (sdram_wr_ack),
        .sdram_rd_ack    (sdram_rd_ack),
        .sdram_dout      (sdram_dout)
    );

endmodule

//--- src/stream_write_buffer.sv
module stream_write_buffer (
    input  logic                  clk,
    input  logic                  sys_rst_n,
    input  sdram_geom_pkg::addr_t address,
    input  sdram_geom_pkg::word_t data_in,
    input  logic                  write_latch_address,
    input  logic                  write_en,
    output sdram_geom_pkg::addr_t write_address,
    burst_job_if.requester        flush
);

    sdram_geom_pkg::addr_t      wr_addr;
    sdram_geom_pkg::addr_t      cur_addr;
    sdram_geom_pkg::block_tag_t blk_tag;
    logic                       copy;

    // slot 15 is never stored in front, it goes straight to back
    sdram_geom_pkg::word_t front_buf [sdram_geom_pkg::STREAM_WORDS - 1];
    sdram_geom_pkg::word_t back_buf  [sdram_geom_pkg::STREAM_WORDS];

    assign cur_addr      = write_latch_address ? address : wr_addr;
    assign copy          = write_en && (cur_addr[3:0] == 4'hf);
    assign write_address = wr_addr;

    assign flush.addr    = {blk_tag, 4'b0000};        // block aligned
    assign flush.wr_word = back_buf[flush.word_idx[3:0]];

    // streaming address counter
    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_addr <= '0;
        end else if (write_en) begin
            wr_addr <= cur_addr + 1'b1;
        end else begin
            wr_addr <= cur_addr;
        end
    end

    // front fill, and handover to back on the last slot
    always_ff @(posedge clk) begin
        if (write_en && !copy) begin
            front_buf[cur_addr[3:0]] <= data_in;
        end
        if (copy) begin
            for (int i = 0; i < sdram_geom_pkg::STREAM_WORDS - 1; i++) begin
                back_buf[i] <= front_buf[i];
            end
            back_buf[sdram_geom_pkg::STREAM_WORDS - 1] <= data_in;
            blk_tag <= cur_addr[23:4];
        end
    end

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            flush.req <= 1'b0;
        end else begin
            if (flush.done) begin
                flush.req <= 1'b0;
            end
            if (copy) begin
                flush.req <= 1'b1;   // hand the block to the sequencer
            end
        end
    end

    // the next block must not complete before the previous flush ends
    a_no_refill : assert property (
        @(posedge clk) disable iff (!sys_rst_n) copy |-> !flush.req
    );

endmodule

//--- src/word_access_port.sv
module word_access_port (
    input  logic                  clk,
    input  logic                  sys_rst_n,
    input  sdram_geom_pkg::addr_t address,
    input  sdram_geom_pkg::word_t data_in,
    input  logic                  read_req,
    input  logic                  write_req,
    input  logic                  write_en,
    output logic                  read_ack,
    output logic                  write_ack,
    output sdram_geom_pkg::word_t data_out,
    burst_job_if.requester        fill,
    burst_job_if.requester        single
);

    logic                      read_req_d;
    logic                      write_req_d;
    logic                      read_rise;
    logic                      write_rise;
    logic                      line_valid;
    logic                      line_hit;
    sdram_geom_pkg::line_tag_t line_tag;
    sdram_geom_pkg::word_t     line_buf [sdram_geom_pkg::LINE_WORDS];
    sdram_geom_pkg::word_t     single_data;

    assign read_rise  = read_req && !read_req_d;
    assign write_rise = write_req && !write_req_d;
    assign line_hit   = line_valid && (line_tag == address[23:2]);

    assign fill.wr_word   = '0;          // fill is a read, no write data
    assign single.wr_word = single_data; // single burst only uses word 0

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            read_req_d  <= 1'b0;
            write_req_d <= 1'b0;
        end else begin
            read_req_d  <= read_req;
            write_req_d <= write_req;
        end
    end

    // read side: hit answers next clock, miss goes through a line fill
    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            read_ack   <= 1'b0;
            data_out   <= '0;
            line_valid <= 1'b0;
            fill.req   <= 1'b0;
        end else begin
            if (read_rise) begin
                if (line_hit) begin
                    read_ack <= 1'b1;
                    data_out <= line_buf[address[1:0]];
                end else begin
                    line_valid <= 1'b0;
                    fill.req   <= 1'b1;
                end
            end else if (fill.done) begin
                fill.req   <= 1'b0;      // drop in the cycle after done
                line_valid <= 1'b1;
                read_ack   <= 1'b1;
                data_out   <= line_buf[address[1:0]]; // last word landed with done
            end
            if (!read_req) begin
                read_ack <= 1'b0;
                data_out <= '0;
            end
            if (write_req || write_en) begin
                line_valid <= 1'b0;      // any write may touch the line
            end
        end
    end

    // line words and tag, filled from the sequencer
    always_ff @(posedge clk) begin
        if (read_rise && !line_hit) begin
            fill.addr <= {address[23:2], 2'b00}; // line aligned
        end
        if (fill.word_stb) begin
            line_buf[fill.word_idx[1:0]] <= fill.rd_word;
        end
        if (fill.done) begin
            line_tag <= address[23:2];
        end
    end

    // single word write
    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            single.req <= 1'b0;
            write_ack  <= 1'b0;
        end else begin
            write_ack <= 1'b0;
            if (write_rise) begin
                single.req <= 1'b1;
            end else if (single.done) begin
                single.req <= 1'b0;
                write_ack  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_rise) begin
            single.addr <= address;
            single_data <= data_in;
        end
    end

    // user must never issue a read and a single write together
    a_rd_wr_excl : assert property (
        @(posedge clk) disable iff (!sys_rst_n) !(read_req && write_req)
    );

endmodule

//--- tests/sdram_ctrl_model.sv
module sdram_ctrl_model (
    input  logic                       clk,
    input  logic                       sys_rst_n,
    input  logic [2:0]                 ack_delay,
    input  sdram_geom_pkg::addr_t      sdram_rw_addr,
    input  logic                       sdram_wr_req,
    input  logic                       sdram_rd_req,
    input  sdram_geom_pkg::burst_len_t sdram_wr_burst,
    input  sdram_geom_pkg::burst_len_t sdram_rd_burst,
    input  sdram_geom_pkg::word_t      sdram_din,
    output logic                       sdram_wr_ack,
    output logic                       sdram_rd_ack,
    output sdram_geom_pkg::word_t      sdram_dout,
    output logic                       sdram_init_done
);

    typedef enum logic [1:0] {M_IDLE, M_WAIT, M_ACK} model_state_e;

    sdram_geom_pkg::word_t      mem [sdram_geom_pkg::addr_t];  // sparse word memory
    model_state_e               state;
    logic [3:0]                 init_cnt;
    logic [2:0]                 wait_cnt;
    sdram_geom_pkg::burst_len_t cnt;
    sdram_geom_pkg::burst_len_t len;

    // words never written read back a pattern of their whole address
    function automatic sdram_geom_pkg::word_t peek(input sdram_geom_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[15:0] ^ {a[23:16], a[23:16]};
    endfunction

    assign len = sdram_rd_req ? sdram_rd_burst : sdram_wr_burst;

    always @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state           <= M_IDLE;
            init_cnt        <= '0;
            wait_cnt        <= '0;
            cnt             <= '0;
            sdram_init_done <= 1'b0;
            sdram_wr_ack    <= 1'b0;
            sdram_rd_ack    <= 1'b0;
            sdram_dout      <= '0;
        end else begin
            if (init_cnt != 4'hf) begin
                init_cnt <= init_cnt + 1'b1;
            end else begin
                sdram_init_done <= 1'b1;   // power-up sequence over
            end
            case (state)
                M_IDLE: begin
                    if (sdram_wr_req || sdram_rd_req) begin
                        wait_cnt <= ack_delay;   // random latency before data
                        cnt      <= '0;
                        state    <= M_WAIT;
                    end
                end
                M_WAIT: begin
                    if (wait_cnt != 3'd0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else begin
                        sdram_wr_ack <= sdram_wr_req;
                        sdram_rd_ack <= sdram_rd_req;
                        sdram_dout   <= sdram_rd_req ? peek(sdram_rw_addr) : '0;
                        state        <= M_ACK;
                    end
                end
                M_ACK: begin
                    if (sdram_wr_ack) begin
                        mem[sdram_geom_pkg::addr_t'(sdram_rw_addr + cnt)] = sdram_din;
                    end
                    cnt <= cnt + 1'b1;
                    if (cnt == len - 1'b1) begin   // last word of the burst
                        sdram_wr_ack <= 1'b0;
                        sdram_rd_ack <= 1'b0;
                        sdram_dout   <= '0;
                        state        <= M_IDLE;
                    end else if (sdram_rd_ack) begin
                        sdram_dout <= peek(sdram_geom_pkg::addr_t'(sdram_rw_addr + cnt + 1'b1));
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

endmodule

//--- tests/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic sys_rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // period 20
    end

    initial begin
        sys_rst_n = 1'b0;
        repeat (16) @(posedge clk);
        sys_rst_n <= 1'b1;
    end

endmodule

//--- tests/tb_sdram_user_bridge.sv
module tb_sdram_user_bridge;

    localparam int N_SINGLE    = 6;
    localparam int WORST_BURST = 8 + sdram_geom_pkg::STREAM_WORDS + 8; // delay, words, handoff
    localparam int OP_TIMEOUT  = 3 * WORST_BURST;   // a job may queue behind a flush
    localparam int N_OPS       = 2 * N_SINGLE + 2 + 2 + 2 * sdram_geom_pkg::STREAM_WORDS + 4;
    localparam int TIMEOUT_TU  = (16 + 16 + N_OPS * WORST_BURST) * 20;

    logic                       clk;
    logic                       sys_rst_n;
    sdram_geom_pkg::addr_t      address;
    sdram_geom_pkg::addr_t      write_address;
    sdram_geom_pkg::addr_t      sdram_rw_addr;
    sdram_geom_pkg::word_t      data_in;
    sdram_geom_pkg::word_t      data_out;
    sdram_geom_pkg::word_t      sdram_din;
    sdram_geom_pkg::word_t      sdram_dout;
    sdram_geom_pkg::burst_len_t sdram_wr_burst;
    sdram_geom_pkg::burst_len_t sdram_rd_burst;
    logic read_req, read_ack, write_req, write_ack, write_latch_address, write_en;
    logic sdram_wr_req, sdram_rd_req, sdram_wr_ack, sdram_rd_ack, sdram_init_done;

    logic [31:0] rnd_state = 32'hae96;
    logic [31:0] dly_state = 32'hae96;
    logic [2:0]  ack_delay;
    sdram_geom_pkg::word_t ref_mem [sdram_geom_pkg::addr_t];   // words written by the tests

    int err_cnt, port_err, test_cnt, test_fail, test_err_base;
    int rd_acks, wr_acks, fill_bursts, single_bursts, flush_cnt;
    logic rd_req_d, wr_req_d;

    tb_clock u_clock (.clk(clk), .sys_rst_n(sys_rst_n));
    sdram_ctrl_model u_ctrl (.*);
    sdram_user_bridge i_dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic sdram_geom_pkg::word_t ref_word(input sdram_geom_pkg::addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a[15:0] ^ {a[23:16], a[23:16]};   // power-up content of the memory
    endfunction

    always @(posedge clk) begin
        dly_state <= xorshift32(dly_state);
    end
    assign ack_delay = dly_state[9:7];

    // burst bookkeeping at the controller port
    always @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rd_acks       <= 0;
            wr_acks       <= 0;
            fill_bursts   <= 0;
            single_bursts <= 0;
            flush_cnt     <= 0;
            rd_req_d      <= 1'b0;
            wr_req_d      <= 1'b0;
        end else begin
            rd_acks  <= sdram_rd_req ? rd_acks + sdram_rd_ack : 0;
            wr_acks  <= sdram_wr_req ? wr_acks + sdram_wr_ack : 0;
            rd_req_d <= sdram_rd_req;
            wr_req_d <= sdram_wr_req;
            if (sdram_rd_req && !rd_req_d) begin
                fill_bursts <= fill_bursts + 1;
            end
            if (sdram_wr_req && !wr_req_d && sdram_wr_burst == 10'd1) begin
                single_bursts <= single_bursts + 1;
            end
            if (wr_req_d && !sdram_wr_req && sdram_wr_burst == 10'd16) begin
                flush_cnt <= flush_cnt + 1;   // flush fully in memory
            end
        end
    end

    a_fill_len : assert property (@(posedge clk) disable iff (!sys_rst_n)
        $rose(sdram_rd_req) |-> sdram_rd_burst == sdram_geom_pkg::LEN_FILL)
    else begin
        $display("[FAIL] %0t sdram_rd_burst expected %0d got %0d", $time,
                 sdram_geom_pkg::LEN_FILL, $sampled(sdram_rd_burst));
        port_err++;
        err_cnt++;
    end

    a_fill_align : assert property (@(posedge clk) disable iff (!sys_rst_n)
        $rose(sdram_rd_req) |-> sdram_rw_addr[1:0] == 2'b00)
    else begin
        $display("[FAIL] %0t sdram_rw_addr[1:0] expected 0 got %0d", $time,
                 $sampled(sdram_rw_addr[1:0]));
        port_err++;
        err_cnt++;
    end

    a_write_shape : assert property (@(posedge clk) disable iff (!sys_rst_n)
        $rose(sdram_wr_req) |-> (sdram_wr_burst == sdram_geom_pkg::LEN_SINGLE)
            || (sdram_wr_burst == sdram_geom_pkg::LEN_FLUSH && sdram_rw_addr[3:0] == 4'h0))
    else begin
        $display("at %0t write burst of %0d words at %h is not a single write or aligned flush",
                 $time, $sampled(sdram_wr_burst), $sampled(sdram_rw_addr));
        port_err++;
        err_cnt++;
    end

    a_rd_acks : assert property (@(posedge clk) disable iff (!sys_rst_n)
        $fell(sdram_rd_req) |-> rd_acks == sdram_rd_burst)
    else begin
        $display("[FAIL] %0t sdram_rd_ack count expected %0d got %0d", $time,
                 $sampled(sdram_rd_burst), $sampled(rd_acks));
        port_err++;
        err_cnt++;
    end

    a_wr_acks : assert property (@(posedge clk) disable iff (!sys_rst_n)
        $fell(sdram_wr_req) |-> wr_acks == sdram_wr_burst)
    else begin
        $display("[FAIL] %0t sdram_wr_ack count expected %0d got %0d", $time,
                 $sampled(sdram_wr_burst), $sampled(wr_acks));
        port_err++;
        err_cnt++;
    end

    task automatic expect_eq(input string sig, input logic [31:0] want, input logic [31:0] got);
        assert (got === want) else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, sig, want, got);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input bit extra_bad);
        test_cnt++;
        if (err_cnt != test_err_base || extra_bad) begin
            test_fail++;
            $display("test %0d %s: failed, %0d errors", test_cnt, name, err_cnt - test_err_base);
        end else begin
            $display("test %0d %s: ok", test_cnt, name);
        end
        test_err_base = err_cnt;
    endtask

    task automatic read_word(input sdram_geom_pkg::addr_t a, input bit want_hit);
        sdram_geom_pkg::word_t want;
        int n;
        want = ref_word(a);
        n = 0;
        @(posedge clk);
        address  <= a;
        read_req <= 1'b1;
        @(posedge clk);            // bridge sees the rising edge here
        @(negedge clk);
        if (want_hit) begin
            expect_eq("read_ack", 1, read_ack);
        end
        while (!read_ack && n < OP_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!read_ack) begin
            $display("read of address %h got no read_ack within %0d cycles", a, OP_TIMEOUT);
            err_cnt++;
        end
        expect_eq("data_out", want, data_out);
        @(posedge clk);
        read_req <= 1'b0;
        @(negedge clk);
        expect_eq("read_ack", 1, read_ack);    // held one more clock
        expect_eq("data_out", want, data_out);
        @(negedge clk);
        expect_eq("read_ack", 0, read_ack);
        expect_eq("data_out", 0, data_out);
    endtask

    task automatic write_word(input sdram_geom_pkg::addr_t a, input sdram_geom_pkg::word_t d);
        int n;
        n = 0;
        @(posedge clk);
        address   <= a;
        data_in   <= d;
        write_req <= 1'b1;
        ref_mem[a] = d;
        @(negedge clk);
        while (!write_ack && n < OP_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!write_ack) begin
            $display("write to address %h got no write_ack within %0d cycles", a, OP_TIMEOUT);
            err_cnt++;
        end
        @(posedge clk);
        write_req <= 1'b0;
        @(negedge clk);
        expect_eq("write_ack", 0, write_ack);   // a pulse, not a level
    endtask

    task automatic stream_block(input sdram_geom_pkg::addr_t base, input bit latch);
        sdram_geom_pkg::word_t d;
        if (latch) begin
            @(posedge clk);
            address             <= base;
            write_latch_address <= 1'b1;
        end
        for (int i = 0; i < sdram_geom_pkg::STREAM_WORDS; i++) begin
            rnd_state = xorshift32(rnd_state);
            d = rnd_state[15:0];
            @(posedge clk);
            write_latch_address <= 1'b0;
            write_en            <= 1'b1;
            data_in             <= d;
            ref_mem[sdram_geom_pkg::addr_t'(base + i)] = d;
            @(negedge clk);
            expect_eq("write_address", sdram_geom_pkg::addr_t'(base + i), write_address);
        end
        @(posedge clk);
        write_en <= 1'b0;
        @(negedge clk);
        expect_eq("write_address", sdram_geom_pkg::addr_t'(base + 16), write_address);
    endtask

    task automatic wait_flushes(input int n);
        int t;
        t = 0;
        while (flush_cnt < n && t < OP_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (flush_cnt < n) begin
            $display("stream flush number %0d did not reach the controller in time", n);
            err_cnt++;
        end
    endtask

    initial begin
        sdram_geom_pkg::addr_t wr_addrs [N_SINGLE];
        sdram_geom_pkg::addr_t a;
        address             = '0;
        data_in             = '0;
        read_req            = 1'b0;
        write_req           = 1'b0;
        write_latch_address = 1'b0;
        write_en            = 1'b0;
        @(posedge sys_rst_n);
        @(negedge clk);
        expect_eq("read_ack", 0, read_ack);
        expect_eq("write_ack", 0, write_ack);
        expect_eq("data_out", 0, data_out);
        expect_eq("write_address", 0, write_address);
        expect_eq("sdram_wr_req", 0, sdram_wr_req);
        expect_eq("sdram_rd_req", 0, sdram_rd_req);
        finish_test("reset values", 1'b0);

        for (int i = 0; i < N_SINGLE; i++) begin
            rnd_state = xorshift32(rnd_state);
            wr_addrs[i] = rnd_state[23:0];
            rnd_state = xorshift32(rnd_state);
            write_word(wr_addrs[i], rnd_state[15:0]);
        end
        for (int i = 0; i < N_SINGLE; i++) begin
            read_word(wr_addrs[i], 1'b0);
        end
        finish_test("single writes read back", 1'b0);

        rnd_state = xorshift32(rnd_state);
        a = {rnd_state[23:2], 2'b01};
        read_word(a, 1'b0);
        read_word(a ^ 24'h2, 1'b1);   // other word of the fetched line
        finish_test("line miss then hit", 1'b0);

        rnd_state = xorshift32(rnd_state);
        a = {rnd_state[23:4], 4'h0};
        stream_block(a, 1'b1);
        wait_flushes(1);
        repeat (2) @(posedge clk);
        stream_block(sdram_geom_pkg::addr_t'(a + 16), 1'b0);   // counter carries on
        wait_flushes(2);
        for (int i = 0; i < 2 * sdram_geom_pkg::STREAM_WORDS; i++) begin
            read_word(sdram_geom_pkg::addr_t'(a + i), (i % 4) != 0);
        end
        finish_test("two stream blocks", 1'b0);

        rnd_state = xorshift32(rnd_state);
        a = {rnd_state[23:2], 2'b00};
        read_word(a, 1'b0);
        read_word(sdram_geom_pkg::addr_t'(a + 1), 1'b1);
        rnd_state = xorshift32(rnd_state);
        write_word(sdram_geom_pkg::addr_t'(a + 1), rnd_state[15:0]);
        read_word(sdram_geom_pkg::addr_t'(a + 1), 1'b0);   // line was dropped by the write
        finish_test("write invalidates line", 1'b0);

        if (fill_bursts == 0 || single_bursts == 0 || flush_cnt == 0) begin
            $display("not every kind of controller burst was issued");
            err_cnt++;
        end
        finish_test("controller port bursts", port_err != 0);

        $display("%0d tests, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0 && test_fail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_TU);
        $display("watchdog expired at %0t before the tests finished", $time);
        $display("TEST FAIL");
        $finish;
    end

endmodule
